// File: common/resizer_pkg.sv
package resizer_pkg;

   ////////////////////
   // frame geometry
   ////////////////////
   localparam int FRAME_W = 8;             // pixels per line
   localparam int FRAME_H = 6;             // lines per frame
   localparam int COL_W   = 4;             // column offset count, -1 .. W+1
   localparam int ROW_W   = 3;             // row index
   localparam int ADDR_W  = 6;             // frame store address

   ////////////////////
   // filter constants
   ////////////////////
   localparam int TAP_OUTER  = -1;         // outer kernel weight
   localparam int TAP_INNER  = 9;          // inner kernel weight
   localparam int ROUND_ADD  = 128;        // half of the 256 gain
   localparam int NORM_SHIFT = 8;          // two passes of 16 each

   ////////////////////
   // shared structs
   ////////////////////
   typedef struct packed {
      logic [7:0] b;
      logic [7:0] g;
      logic [7:0] r;
   } pixel_t;

   // one window column, one pixel per row
   typedef struct packed {
      pixel_t row0;                        // top, row y-1
      pixel_t row1;                        // row y
      pixel_t row2;                        // row y+1
      pixel_t row3;                        // bottom, row y+2
   } column_t;

   typedef struct packed {
      logic col_valid;                     // window complete after this column
      logic eol;                           // last output of a line
      logic eof;                           // last output of the frame
   } beat_tag_t;

endpackage

// File: logic/frame_ctrl.sv
`timescale 1ns/10ps

module frame_ctrl import resizer_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_rstn,
   input  logic                   i_s_valid,
   input  logic [31:0]            i_s_data,     // {pad,b,g,r}
   output logic                   o_s_ready,
   input  logic                   i_advance,
   input  logic                   i_frame_done,
   output logic                   o_wr_en,
   output logic [ADDR_W-1:0]      o_wr_addr,
   output pixel_t                 o_wr_pix,
   output logic                   o_rd_en,
   output logic [3:0][ADDR_W-1:0] o_rd_addr,    // index 0 is the top row
   output beat_tag_t              o_rd_tag
);

   typedef enum logic [1:0] {
      ST_WRITE,
      ST_READ,
      ST_DRAIN
   } state_t;

   state_t            state;
   logic [ADDR_W-1:0] wr_cnt;                   // raster write position
   logic [ROW_W-1:0]  rd_y;                     // output row
   logic [COL_W-1:0]  rd_col;                   // 0 means column -1
   logic [COL_W-1:0]  col_clamp;
   logic [ROW_W-1:0]  row_clamp [4];
   logic              last_pix;
   logic              last_col;
   logic              last_row;

   function automatic logic [ADDR_W-1:0] pix_addr(input logic [ROW_W-1:0] row,
                                                  input logic [COL_W-1:0] col);
      pix_addr = ADDR_W'(row * FRAME_W + col);
   endfunction

   ////////////////////
   // write phase
   ////////////////////
   assign o_s_ready = (state == ST_WRITE);
   assign o_wr_en   = i_s_valid & o_s_ready;
   assign o_wr_addr = wr_cnt;
   assign o_wr_pix  = pixel_t'(i_s_data[23:0]);  // pad byte dropped
   assign last_pix  = (wr_cnt == ADDR_W'(FRAME_W * FRAME_H - 1));

   ////////////////////
   // read phase
   ////////////////////
   assign last_col = (rd_col == COL_W'(FRAME_W + 2));
   assign last_row = (rd_y == ROW_W'(FRAME_H - 1));

   // clamp offsets into the frame, left/right then top/bottom
   always_comb begin
      if (rd_col == '0)
         col_clamp = '0;
      else if (rd_col > COL_W'(FRAME_W))
         col_clamp = COL_W'(FRAME_W - 1);
      else
         col_clamp = rd_col - 1'b1;

      row_clamp[0] = (rd_y == '0) ? '0 : rd_y - 1'b1;
      row_clamp[1] = rd_y;
      row_clamp[2] = last_row ? ROW_W'(FRAME_H - 1) : rd_y + 1'b1;
      row_clamp[3] = (rd_y >= ROW_W'(FRAME_H - 2)) ? ROW_W'(FRAME_H - 1) : rd_y + 2'd2;
   end

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         o_rd_addr[k] = pix_addr(row_clamp[k], col_clamp);
      end
   end

   // bubbles outside the read phase flush the pipeline with zero tags
   assign o_rd_en            = i_advance;
   assign o_rd_tag.col_valid = (state == ST_READ) && (rd_col >= COL_W'(3)); // 4th column on
   assign o_rd_tag.eol       = o_rd_tag.col_valid & last_col;
   assign o_rd_tag.eof       = o_rd_tag.col_valid & last_col & last_row;

   ////////////////////
   // sequencing
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state  <= ST_WRITE;
         wr_cnt <= '0;
         rd_y   <= '0;
         rd_col <= '0;
      end else begin
         case (state)
            ST_WRITE: begin
               if (o_wr_en) begin
                  if (last_pix) begin
                     wr_cnt <= '0;
                     state  <= ST_READ;                // ready drops next cycle
                  end else begin
                     wr_cnt <= wr_cnt + 1'b1;
                  end
               end
            end
            ST_READ: begin
               if (i_advance) begin
                  if (last_col) begin
                     rd_col <= '0;
                     if (last_row) begin
                        rd_y  <= '0;
                        state <= ST_DRAIN;
                     end else begin
                        rd_y <= rd_y + 1'b1;
                     end
                  end else begin
                     rd_col <= rd_col + 1'b1;
                  end
               end
            end
            ST_DRAIN: begin
               if (i_frame_done) state <= ST_WRITE;    // eof beat accepted
            end
            default: state <= ST_WRITE;
         endcase
      end
   end

endmodule

// File: logic/frame_store.sv
`timescale 1ns/10ps

module frame_store import resizer_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_wr_en,
   input  logic [ADDR_W-1:0]      i_wr_addr,
   input  pixel_t                 i_wr_pix,
   input  logic                   i_rd_en,
   input  logic [3:0][ADDR_W-1:0] i_rd_addr,    // top row first
   input  beat_tag_t              i_rd_tag,
   output column_t                o_col,
   output beat_tag_t              o_tag
);

   pixel_t mem [FRAME_W * FRAME_H];             // raster order

   ////////////////////
   // write port
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_pix;
      end
   end

   ////////////////////
   // four read ports
   ////////////////////
   // all four rows of a column land in the same cycle, tag beside them
   always_ff @(posedge i_clk) begin
      if (i_rd_en) begin                        // stall holds the column
         o_col.row0 <= mem[i_rd_addr[0]];
         o_col.row1 <= mem[i_rd_addr[1]];
         o_col.row2 <= mem[i_rd_addr[2]];
         o_col.row3 <= mem[i_rd_addr[3]];
         o_tag      <= i_rd_tag;
      end
   end

endmodule

// File: bicubic/window_shift.sv
`timescale 1ns/10ps

module window_shift import resizer_pkg::*; (
   input  logic           i_clk,
   input  logic           i_rstn,
   input  logic           i_advance,
   input  column_t        i_col,
   input  beat_tag_t      i_tag,
   output column_t [3:0]  o_win,              // [0] oldest, column x-1
   output beat_tag_t      o_tag
);

   ////////////////////
   // column shift
   ////////////////////
   // newest column enters at [3], window spans x-1 .. x+2
   always_ff @(posedge i_clk) begin
      if (i_advance) begin
         o_win[0] <= o_win[1];
         o_win[1] <= o_win[2];
         o_win[2] <= o_win[3];
         o_win[3] <= i_col;
      end
   end

   ////////////////////
   // fill state
   ////////////////////
   // The tag follows the column that just shifted in. Its col_valid is
   // only set once four columns of the current line are in the window,
   // so it marks a complete 4x4 neighbourhood for the filter.
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_tag <= '0;                             // empty window
      end else if (i_advance) begin
         o_tag <= i_tag;
      end
   end

endmodule

// File: bicubic/bicubic_filter.sv
`timescale 1ns/10ps

module bicubic_filter import resizer_pkg::*; (
   input  logic          i_clk,
   input  logic          i_rstn,
   input  logic          i_m_ready,
   input  column_t [3:0] i_win,
   input  beat_tag_t     i_tag,
   output logic          o_advance,
   output logic          o_frame_done,
   output pixel_t        o_m_data,
   output logic          o_m_valid,
   output logic          o_m_eol,
   output logic          o_m_eof
);

   typedef struct packed {
      logic signed [13:0] b;
      logic signed [13:0] g;
      logic signed [13:0] r;
   } hsum_t;                                  // -510 .. 4590 per channel

   hsum_t [3:0] s1_sum;                       // one per window row
   beat_tag_t   s1_tag;
   pixel_t      v_pix;

   function automatic logic signed [13:0] tap_h(input logic [7:0] a, b, c, d);
      tap_h = 14'(TAP_OUTER * $signed({1'b0, a}) + TAP_INNER * $signed({1'b0, b}) +
                  TAP_INNER * $signed({1'b0, c}) + TAP_OUTER * $signed({1'b0, d}));
   endfunction

   function automatic hsum_t h_pass(input column_t [3:0] win, input int row);
      pixel_t p [4];
      for (int k = 0; k < 4; k++) begin
         case (row)
            0:       p[k] = win[k].row0;
            1:       p[k] = win[k].row1;
            2:       p[k] = win[k].row2;
            default: p[k] = win[k].row3;
         endcase
      end
      h_pass.b = tap_h(p[0].b, p[1].b, p[2].b, p[3].b);
      h_pass.g = tap_h(p[0].g, p[1].g, p[2].g, p[3].g);
      h_pass.r = tap_h(p[0].r, p[1].r, p[2].r, p[3].r);
   endfunction

   // vertical pass, round, normalise, clip to a byte
   function automatic logic [7:0] v_pass(input logic signed [13:0] a, b, c, d);
      logic signed [19:0] acc;
      acc = 20'(TAP_OUTER * a + TAP_INNER * b + TAP_INNER * c + TAP_OUTER * d + ROUND_ADD);
      acc = acc >>> NORM_SHIFT;
      if (acc < 0)
         v_pass = 8'd0;
      else if (acc > 20'sd255)
         v_pass = 8'd255;
      else
         v_pass = acc[7:0];
   endfunction

   assign o_advance    = !o_m_valid | i_m_ready;   // output empty or leaving
   assign o_frame_done = o_m_valid & i_m_ready & o_m_eof;

   ////////////////////
   // stage 1, rows
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (o_advance) begin
         for (int r = 0; r < 4; r++) begin
            s1_sum[r] <= h_pass(i_win, r);
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn)        s1_tag <= '0;
      else if (o_advance) s1_tag <= i_tag;
   end

   ////////////////////
   // stage 2, output
   ////////////////////
   assign v_pix.b = v_pass(s1_sum[0].b, s1_sum[1].b, s1_sum[2].b, s1_sum[3].b);
   assign v_pix.g = v_pass(s1_sum[0].g, s1_sum[1].g, s1_sum[2].g, s1_sum[3].g);
   assign v_pix.r = v_pass(s1_sum[0].r, s1_sum[1].r, s1_sum[2].r, s1_sum[3].r);

   always_ff @(posedge i_clk) begin
      if (o_advance && s1_tag.col_valid) o_m_data <= v_pix;   // partial windows skipped
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_m_valid <= 1'b0;
         o_m_eol   <= 1'b0;
         o_m_eof   <= 1'b0;
      end else if (o_advance) begin
         o_m_valid <= s1_tag.col_valid;
         o_m_eol   <= s1_tag.col_valid & s1_tag.eol;
         o_m_eof   <= s1_tag.col_valid & s1_tag.eof;
      end
   end

endmodule

// File: logic/bicubic_resizer.sv
`timescale 1ns/10ps

module bicubic_resizer import resizer_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rstn,
   input  logic [31:0] i_s_data,              // {pad,b,g,r}
   input  logic        i_s_valid,
   output logic        o_s_ready,
   output pixel_t      o_m_data,
   output logic        o_m_valid,
   output logic        o_m_eol,
   output logic        o_m_eof,
   input  logic        i_m_ready
);

   logic                   wr_en;
   logic [ADDR_W-1:0]      wr_addr;
   pixel_t                 wr_pix;
   logic                   rd_en;
   logic [3:0][ADDR_W-1:0] rd_addr;
   beat_tag_t              rd_tag;
   column_t                st_col;
   beat_tag_t              st_tag;
   column_t [3:0]          win;
   beat_tag_t              win_tag;
   logic                   advance;           // read pipeline enable
   logic                   frame_done;

   ////////////////////
   // control and store
   ////////////////////
   frame_ctrl u_frame_ctrl (
      .i_clk        (i_clk),
      .i_rstn       (i_rstn),
      .i_s_valid    (i_s_valid),
      .i_s_data     (i_s_data),
      .o_s_ready    (o_s_ready),
      .i_advance    (advance),
      .i_frame_done (frame_done),
      .o_wr_en      (wr_en),
      .o_wr_addr    (wr_addr),
      .o_wr_pix     (wr_pix),
      .o_rd_en      (rd_en),
      .o_rd_addr    (rd_addr),
      .o_rd_tag     (rd_tag)
   );

   frame_store u_frame_store (
      .i_clk     (i_clk),
      .i_wr_en   (wr_en),
      .i_wr_addr (wr_addr),
      .i_wr_pix  (wr_pix),
      .i_rd_en   (rd_en),
      .i_rd_addr (rd_addr),
      .i_rd_tag  (rd_tag),
      .o_col     (st_col),
      .o_tag     (st_tag)
   );

   ////////////////////
   // interpolation
   ////////////////////
   window_shift u_window_shift (
      .i_clk     (i_clk),
      .i_rstn    (i_rstn),
      .i_advance (advance),
      .i_col     (st_col),
      .i_tag     (st_tag),
      .o_win     (win),
      .o_tag     (win_tag)
   );

   bicubic_filter u_bicubic_filter (
      .i_clk        (i_clk),
      .i_rstn       (i_rstn),
      .i_m_ready    (i_m_ready),
      .i_win        (win),
      .i_tag        (win_tag),
      .o_advance    (advance),
      .o_frame_done (frame_done),
      .o_m_data     (o_m_data),
      .o_m_valid    (o_m_valid),
      .o_m_eol      (o_m_eol),
      .o_m_eof      (o_m_eof)
   );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_rstn
);

   localparam real HALF_PERIOD = 10.0;        // 20 ns clock
   localparam int  RESET_CYCLES = 5;

   initial begin
      o_clk  = 1'b0;
      o_rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rstn <= 1'b1;                          // released on a rising edge
   end

   always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

// File: verification/bicubic_resizer_sva.sv
`timescale 1ns/10ps

module bicubic_resizer_sva import resizer_pkg::*; (
   input logic   i_clk,
   input logic   i_rstn,
   input logic   i_s_ready,
   input logic   i_m_valid,
   input pixel_t i_m_data,
   input logic   i_m_eol,
   input logic   i_m_eof,
   input logic   i_m_ready
);

   int assert_errs = 0;                       // failed assertions so far

   // a beat that is not taken stays put
   a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
      i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_data) &&
                                  $stable(i_m_eol) && $stable(i_m_eof))
      else begin
         $error("stalled output beat was not held");
         assert_errs++;
      end

   // input and output phases never overlap
   a_phase_excl: assert property (@(posedge i_clk) disable iff (!i_rstn)
      !(i_s_ready && i_m_valid))
      else begin
         $error("input ready and output valid high together");
         assert_errs++;
      end

   a_after_reset: assert property (@(posedge i_clk)
      $rose(i_rstn) |-> i_s_ready && !i_m_valid)
      else begin
         $error("wrong handshake state after reset");
         assert_errs++;
      end

endmodule

bind bicubic_resizer bicubic_resizer_sva u_resizer_sva (
   .i_clk     (i_clk),
   .i_rstn    (i_rstn),
   .i_s_ready (o_s_ready),
   .i_m_valid (o_m_valid),
   .i_m_data  (o_m_data),
   .i_m_eol   (o_m_eol),
   .i_m_eof   (o_m_eof),
   .i_m_ready (i_m_ready)
);

// File: verification/bicubic_resizer_tb.sv
`timescale 1ns/10ps

module bicubic_resizer_tb import resizer_pkg::*; ();

   localparam int N_PIX      = FRAME_W * FRAME_H;
   localparam int N_TESTS    = 8;
   localparam int TIMEOUT    = 1000;          // cycles without progress
   localparam int ROUND_HALF = 128;           // kernel gain is 16 * 16
   localparam int GAIN_SHIFT = 8;

   typedef enum logic [1:0] {PAT_CONST, PAT_HRAMP, PAT_VSTEP, PAT_RANDOM} pattern_t;
   typedef enum logic [1:0] {RDY_ALWAYS, RDY_ALTERNATE, RDY_RANDOM} ready_t;

   typedef struct {
      pattern_t pattern;
      pixel_t   value;
      ready_t   ready;
      string    name;
   } test_row_t;

   logic        clk;
   logic        rstn;
   logic [31:0] s_data;
   logic        s_valid;
   logic        s_ready;
   pixel_t      m_data;
   logic        m_valid;
   logic        m_eol;
   logic        m_eof;
   logic        m_ready;

   test_row_t   test_table [N_TESTS];
   pixel_t      frame [N_PIX];                 // raster order
   logic [31:0] rng_state = 32'he387_f34e;
   int          test_errs;

   tb_clock_gen u_clock_gen (.o_clk(clk), .o_rstn(rstn));

   bicubic_resizer i_bicubic_resizer (
      .i_clk     (clk),
      .i_rstn    (rstn),
      .i_s_data  (s_data),
      .i_s_valid (s_valid),
      .o_s_ready (s_ready),
      .o_m_data  (m_data),
      .o_m_valid (m_valid),
      .o_m_eol   (m_eol),
      .o_m_eof   (m_eof),
      .i_m_ready (m_ready)
   );

   task automatic load_table();
      test_table[0] = '{PAT_CONST,  24'h80_80_80, RDY_ALWAYS,    "flat grey"};
      test_table[1] = '{PAT_CONST,  24'h1f_c4_73, RDY_ALTERNATE, "flat colour"};
      test_table[2] = '{PAT_HRAMP,  24'h00_00_10, RDY_ALWAYS,    "horizontal ramp"};
      test_table[3] = '{PAT_VSTEP,  24'h10_f0_80, RDY_ALWAYS,    "vertical step"};
      test_table[4] = '{PAT_RANDOM, 24'h00_00_00, RDY_ALWAYS,    "random near rails"};
      test_table[5] = '{PAT_HRAMP,  24'h00_00_40, RDY_ALTERNATE, "ramp, alternate ready"};
      test_table[6] = '{PAT_RANDOM, 24'h00_00_00, RDY_RANDOM,    "random, random ready"};
      test_table[7] = '{PAT_VSTEP,  24'h00_ff_20, RDY_RANDOM,    "step, random ready"};
   endtask

   ////////////////////
   // stimulus helpers
   ////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [7:0] near_rail(input logic [7:0] r);
      return r[7] ? {4'hf, r[3:0]} : {4'h0, r[3:0]};   // 0..15 or 240..255
   endfunction

   task automatic build_frame(input test_row_t t);
      pixel_t p;
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            case (t.pattern)
               PAT_CONST: p = t.value;
               PAT_HRAMP: begin
                  p.b = 8'(x * 36);
                  p.g = 8'(255 - x * 36);
                  p.r = 8'(t.value.r + x * 20);
               end
               PAT_VSTEP: p = (y < FRAME_H / 2) ? t.value : ~t.value;
               default: begin
                  rng_state = xorshift32(rng_state);
                  p.b = near_rail(rng_state[7:0]);
                  p.g = near_rail(rng_state[15:8]);
                  p.r = near_rail(rng_state[23:16]);
               end
            endcase
            frame[y * FRAME_W + x] = p;
         end
      end
   endtask

   ////////////////////
   // reference model
   ////////////////////
   function automatic int clamp_idx(input int v, input int hi);
      if (v < 0) return 0;
      if (v > hi) return hi;
      return v;
   endfunction

   function automatic int tap_weight(input int i);
      return (i == 1 || i == 2) ? 9 : -1;
   endfunction

   function automatic int channel(input pixel_t p, input int c);
      case (c)
         0:       return int'(p.b);
         1:       return int'(p.g);
         default: return int'(p.r);
      endcase
   endfunction

   // midpoint of (x,y)..(x+1,y+1) from the clamped 4x4 neighbourhood
   function automatic pixel_t model_pixel(input int x, input int y);
      int     hsum;
      int     acc;
      int     yj;
      pixel_t p;
      pixel_t res;
      res = '0;
      for (int c = 0; c < 3; c++) begin
         acc = ROUND_HALF;
         for (int j = 0; j < 4; j++) begin
            hsum = 0;
            yj   = clamp_idx(y + j - 1, FRAME_H - 1);
            for (int i = 0; i < 4; i++) begin
               p    = frame[yj * FRAME_W + clamp_idx(x + i - 1, FRAME_W - 1)];
               hsum += tap_weight(i) * channel(p, c);
            end
            acc += tap_weight(j) * hsum;
         end
         acc = acc >>> GAIN_SHIFT;             // floor division
         if (acc < 0) acc = 0;
         else if (acc > 255) acc = 255;
         case (c)
            0:       res.b = 8'(acc);
            1:       res.g = 8'(acc);
            default: res.r = 8'(acc);
         endcase
      end
      return res;
   endfunction

   ////////////////////
   // checks
   ////////////////////
   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_pixel(input pixel_t exp, input pixel_t act, input int x, input int y);
      if (act !== exp) begin
         $display("Error at %0t ns: o_m_data at (%0d,%0d) expected %06h, actual %06h",
                  $time, x, y, exp, act);
         test_errs++;
      end
   endtask

   // starts right after a clock edge and drives the first pixel at once
   task automatic send_frame(output bit ok);
      int n;
      int idle;
      n    = 0;
      idle = 0;
      ok   = 1'b1;
      s_valid <= 1'b1;
      s_data  <= {8'h5c, frame[0]};
      while (n < N_PIX) begin
         @(posedge clk);
         if (s_valid && s_ready) begin
            n++;
            idle = 0;
            if (n < N_PIX) s_data <= {8'(n * 37 + 5), frame[n]};   // pad varies
            else s_valid <= 1'b0;
         end else if (++idle > TIMEOUT) begin
            $display("Timeout: input pixel %0d was not accepted", n);
            s_valid <= 1'b0;
            ok = 1'b0;
            return;
         end
      end
   endtask

   task automatic collect_frame(input ready_t mode, output bit ok);
      int beat;
      int idle;
      bit done;
      beat = 0;
      idle = 0;
      done = 1'b0;
      ok   = 1'b1;
      while (!done) begin
         @(posedge clk);
         check_bit("o_s_ready", 1'b0, s_ready);   // input closed during readout
         if (m_valid && m_ready) begin
            check_pixel(model_pixel(beat % FRAME_W, beat / FRAME_W), m_data,
                        beat % FRAME_W, beat / FRAME_W);
            check_bit("o_m_eol", (beat % FRAME_W) == FRAME_W - 1, m_eol);
            check_bit("o_m_eof", beat == N_PIX - 1, m_eof);
            beat++;
            idle = 0;
            done = m_eof || (beat == N_PIX);
         end else if (++idle > TIMEOUT) begin
            $display("Timeout: output beat %0d did not arrive", beat);
            ok = 1'b0;
            return;
         end
         case (mode)
            RDY_ALWAYS:    m_ready <= 1'b1;
            RDY_ALTERNATE: m_ready <= ~m_ready;
            default: begin
               rng_state = xorshift32(rng_state);
               m_ready <= rng_state[0];
            end
         endcase
      end
      if (beat != N_PIX) begin
         $display("Frame ended after %0d output beats instead of %0d", beat, N_PIX);
         test_errs++;
      end
      @(posedge clk);
      check_bit("o_s_ready", 1'b1, s_ready);      // open again after eof
      check_bit("o_m_valid", 1'b0, m_valid);
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      bit ok;
      int idle;
      int pass_cnt;
      int fail_cnt;
      int total_errs;
      int sva_base;
      int sva_now;
      s_valid    = 1'b0;
      s_data     = '0;
      m_ready    = 1'b0;
      ok         = 1'b1;
      idle       = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      total_errs = 0;
      test_errs  = 0;
      sva_base   = 0;
      sva_now    = 0;
      load_table();

      while (rstn !== 1'b1 && ok) begin
         @(posedge clk);
         if (++idle > TIMEOUT) begin
            $display("Timeout: reset was never released");
            ok = 1'b0;
         end
      end
      if (ok) begin
         @(posedge clk);
         check_bit("o_s_ready", 1'b1, s_ready);
         check_bit("o_m_valid", 1'b0, m_valid);
      end

      for (int t = 0; t < N_TESTS && ok; t++) begin
         build_frame(test_table[t]);
         send_frame(ok);
         if (ok) collect_frame(test_table[t].ready, ok);
         if (!ok) test_errs++;
         sva_now   = i_bicubic_resizer.u_resizer_sva.assert_errs;
         test_errs += sva_now - sva_base;        // assertion failures in this test
         sva_base  = sva_now;
         if (test_errs == 0) begin
            pass_cnt++;
            $display("Test %0d (%s): pass", t, test_table[t].name);
         end else begin
            fail_cnt++;
            $display("Test %0d (%s): FAIL with %0d errors", t, test_table[t].name, test_errs);
         end
         total_errs += test_errs;
         test_errs  = 0;
      end

      $display("Summary: %0d of %0d tests run, passed %0d, failed %0d, errors %0d",
               pass_cnt + fail_cnt, N_TESTS, pass_cnt, fail_cnt, total_errs);
      if (ok && fail_cnt == 0 && pass_cnt == N_TESTS && total_errs == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: sources.f
common/resizer_pkg.sv
logic/frame_ctrl.sv
logic/frame_store.sv
bicubic/window_shift.sv
bicubic/bicubic_filter.sv
logic/bicubic_resizer.sv
verification/tb_clock_gen.sv
verification/bicubic_resizer_sva.sv
verification/bicubic_resizer_tb.sv
